//--- sim/cp0_golden.txt
# test op a b c d, hex fields. mtc0/rw: a=addr b=data d=readback. mfc0: a=addr d=expected
# exc: a=code b=pc c=badaddr d=bd. eret: d=epc. cnt: a=cycles b=start. irq: a=level b=timeout
regs   rw    60 ffffffff 0 0040ff03
regs   rw    70 12345678 0 12345678
regs   rw    58 ffffffff 0 ffffffff
regs   rw    00 ffffffff 0 0000000f
regs   rw    50 ffffffff 0 ffffe0ff
regs   rw    10 ffffffff 0 03ffffff
regs   rw    18 5a5a5a5a 0 025a5a5a
regs   rw    68 ffffffff 0 00000300
regs   mfc0  61 0 0 00000000
exc    mtc0  68 00000000 0 0
exc    mtc0  60 00000000 0 0
exc    exc   04 bfc00103 00000000 1
exc    mfc0  70 0 0 bfc000ff
exc    mfc0  68 0 0 80000010
exc    mfc0  60 0 0 00400002
exc    mfc0  40 0 0 bfc00103
exc    exc   05 80001000 a0000007 0
exc    mfc0  70 0 0 bfc000ff
exc    mfc0  68 0 0 80000014
exc    mfc0  40 0 0 a0000007
eret   eret  0 0 0 bfc000ff
eret   mfc0  60 0 0 00400000
timer  mtc0  48 00001000 0 0
timer  cnt   9 00001000 0 0
timer  rw    60 00008001 0 00408001
timer  pend  0 0 0 0
timer  mtc0  48 00002000 0 0
timer  mtc0  58 00002004 0 0
timer  irq   1 28 0 0
timer  mfc0  68 0 0 c0008014
timer  mtc0  58 ffffffff 0 0
timer  irq   0 8 0 0
ext    ext   2a 0 0 0
ext    wait  1 0 0 0
ext    mfc0  68 0 0 8000a814
ext    pend  1 0 0 0
ext    ext   15 0 0 0
ext    wait  1 0 0 0
ext    mfc0  68 0 0 80005414
ext    pend  0 0 0 0
ext    mtc0  60 00001001 0 0
ext    pend  1 0 0 0
ext    mtc0  60 00001003 0 0
ext    pend  0 0 0 0
ext    ext   00 0 0 0
tlb    mtc0  00 00000003 0 0
tlb    mtc0  50 12346055 0 0
tlb    mtc0  10 01234567 0 0
tlb    mtc0  18 02aaaaa8 0 0
tlb    tlbwi 0 0 0 0
tlb    mtc0  00 00000009 0 0
tlb    mtc0  50 fedcc0aa 0 0
tlb    mtc0  10 00000005 0 0
tlb    mtc0  18 03ffffff 0 0
tlb    tlbwi 0 0 0 0
tlb    mtc0  50 00000000 0 0
tlb    mtc0  10 00000000 0 0
tlb    mtc0  18 00000000 0 0
tlb    mtc0  00 00000003 0 0
tlb    tlbr  0 0 0 0
tlb    mfc0  50 0 0 12346055
tlb    mfc0  10 0 0 01234566
tlb    mfc0  18 0 0 02aaaaa8
tlb    mtc0  00 00000009 0 0
tlb    tlbr  0 0 0 0
tlb    mfc0  50 0 0 fedcc0aa
tlb    mfc0  10 0 0 00000005
tlb    mfc0  18 0 0 03ffffff

//--- files.f
rtl/cp0_pkg.sv
rtl/cp0_timer.sv
rtl/cp0_core.sv
rtl/cp0_tlb_regs.sv
rtl/tlb_array.sv
rtl/cp0_top.sv
sim/tb_cp0.sv

//--- run.sh
#!/bin/sh
# Build and run the CP0 testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --top-module tb_cp0 -f files.f -o tb_cp0_sim

out=$(./obj_dir/tb_cp0_sim)
echo "$out"
echo "$out" | grep -q "^No errors$"

//--- sim/tb_cp0.sv
module tb_cp0;

    logic                clk;
    logic                reset;
    logic                ws_valid;
    logic                ws_ex;
    logic                ws_bd;
    logic                inst_mtc0;
    logic                inst_eret;
    logic                inst_tlbr;
    logic                inst_tlbwi;
    logic [4:0]          ws_rd;
    logic [2:0]          ws_sel;
    cp0_pkg::word_t      ws_result;
    cp0_pkg::word_t      ws_pc;
    cp0_pkg::word_t      ws_badaddr;
    cp0_pkg::exc_code_t  exc_code;
    logic [5:0]          ext_int;
    cp0_pkg::word_t      cp0_rdata;
    logic                eret_flush;
    cp0_pkg::word_t      epc;
    logic                int_pending;

    int    errors;
    int    test_errors;
    int    tests_passed;
    int    tests_failed;
    string test_name;

    cp0_top UUT (
        .clk         (clk),
        .reset       (reset),
        .ws_valid    (ws_valid),
        .ws_ex       (ws_ex),
        .ws_bd       (ws_bd),
        .inst_mtc0   (inst_mtc0),
        .inst_eret   (inst_eret),
        .inst_tlbr   (inst_tlbr),
        .inst_tlbwi  (inst_tlbwi),
        .ws_rd       (ws_rd),
        .ws_sel      (ws_sel),
        .ws_result   (ws_result),
        .ws_pc       (ws_pc),
        .ws_badaddr  (ws_badaddr),
        .exc_code    (exc_code),
        .ext_int     (ext_int),
        .cp0_rdata   (cp0_rdata),
        .eret_flush  (eret_flush),
        .epc         (epc),
        .int_pending (int_pending)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #50 clk = ~clk;
        end
    end

    // Inputs change 10 units after the rising edge
    task automatic next_cycle();
        @(posedge clk);
        #10;
    endtask

    task automatic clear_strobes();
        ws_valid   = 1'b0;
        ws_ex      = 1'b0;
        ws_bd      = 1'b0;
        inst_mtc0  = 1'b0;
        inst_eret  = 1'b0;
        inst_tlbr  = 1'b0;
        inst_tlbwi = 1'b0;
    endtask

    task automatic check_word(input string sig, input cp0_pkg::word_t exp,
                              input cp0_pkg::word_t act);
        if (act !== exp) begin
            $display("error at time %0t: %s expected %h, got %h", $time, sig, exp, act);
            test_errors++;
        end
    endtask

    task automatic check_bit(input string sig, input logic exp, input logic act);
        if (act !== exp) begin
            $display("error at time %0t: %s expected %b, got %b", $time, sig, exp, act);
            test_errors++;
        end
    endtask

    task automatic check_range(input string sig, input cp0_pkg::word_t lo,
                               input cp0_pkg::word_t hi, input cp0_pkg::word_t act);
        if ($isunknown(act) || act < lo || act > hi) begin
            $display("error at time %0t: %s expected %h..%h, got %h", $time, sig, lo, hi, act);
            test_errors++;
        end
    endtask

    task automatic write_reg(input cp0_pkg::cp0_addr_t addr, input cp0_pkg::word_t data);
        next_cycle();
        ws_valid  = 1'b1;
        inst_mtc0 = 1'b1;
        ws_rd     = addr[7:3];
        ws_sel    = addr[2:0];
        ws_result = data;
        next_cycle();                // Strobe edge has passed
        clear_strobes();
    endtask

    task automatic read_reg(input cp0_pkg::cp0_addr_t addr, output cp0_pkg::word_t data);
        next_cycle();
        ws_rd  = addr[7:3];
        ws_sel = addr[2:0];
        #30;                         // Mid cycle where the mux has settled
        data = cp0_rdata;
    endtask

    task automatic wait_pending(input logic level, input int limit);
        int cycles;
        cycles = 0;
        while (int_pending !== level && cycles < limit) begin
            next_cycle();
            cycles++;
        end
        if (int_pending !== level) begin
            $display("timeout: int_pending did not reach %b within %0d cycles", level, limit);
            test_errors++;
        end
    endtask

    task automatic end_test();
        if (test_errors == 0) begin
            $display("test %s: ok", test_name);
            tests_passed++;
        end else begin
            $display("test %s: %0d mismatches", test_name, test_errors);
            tests_failed++;
        end
        errors += test_errors;
        test_errors = 0;
    endtask

    task automatic run_row(input string op, input cp0_pkg::word_t a, input cp0_pkg::word_t b,
                           input cp0_pkg::word_t c, input cp0_pkg::word_t d);
        cp0_pkg::word_t rdata;
        if (op == "mtc0") begin
            write_reg(a[7:0], b);
        end else if (op == "rw") begin
            write_reg(a[7:0], b);
            read_reg(a[7:0], rdata);
            check_word("cp0_rdata", d, rdata);
        end else if (op == "mfc0") begin
            read_reg(a[7:0], rdata);
            check_word("cp0_rdata", d, rdata);
        end else if (op == "exc") begin
            next_cycle();
            ws_valid   = 1'b1;
            ws_ex      = 1'b1;
            exc_code   = a[4:0];
            ws_pc      = b;
            ws_badaddr = c;
            ws_bd      = d[0];
            next_cycle();
            clear_strobes();
        end else if (op == "eret") begin
            next_cycle();
            ws_valid  = 1'b1;
            inst_eret = 1'b1;
            #30;
            check_bit("eret_flush", 1'b1, eret_flush);
            next_cycle();
            clear_strobes();
            check_word("epc", d, epc);
        end else if (op == "tlbwi" || op == "tlbr") begin
            next_cycle();
            ws_valid   = 1'b1;
            inst_tlbwi = (op == "tlbwi");
            inst_tlbr  = (op == "tlbr");
            next_cycle();
            clear_strobes();
        end else if (op == "ext") begin
            next_cycle();
            ext_int = a[5:0];
        end else if (op == "wait") begin
            repeat (a) next_cycle();
        end else if (op == "cnt") begin
            repeat (a - 1) next_cycle();   // read_reg adds the last edge
            read_reg(cp0_pkg::COUNT_ADDR, rdata);
            check_range("count", b + (a >> 1), b + ((a + 1) >> 1), rdata);
        end else if (op == "pend") begin
            next_cycle();
            #30;
            check_bit("int_pending", a[0], int_pending);
        end else if (op == "irq") begin
            wait_pending(a[0], b);
        end else begin
            $display("unknown operation %s in the stimulus file", op);
            test_errors++;
        end
    endtask

    initial begin
        int             fd;
        int             rc;
        int             fields;
        string          line;
        string          name;
        string          op;
        cp0_pkg::word_t a;
        cp0_pkg::word_t b;
        cp0_pkg::word_t c;
        cp0_pkg::word_t d;

        reset = 1'b1;
        clear_strobes();
        ws_rd        = '0;
        ws_sel       = '0;
        ws_result    = '0;
        ws_pc        = '0;
        ws_badaddr   = '0;
        exc_code     = '0;
        ext_int      = '0;
        errors       = 0;
        test_errors  = 0;
        tests_passed = 0;
        tests_failed = 0;
        test_name    = "";

        repeat (5) @(posedge clk);
        #10;
        reset = 1'b0;

        fd = $fopen("sim/cp0_golden.txt", "r");
        if (fd == 0) begin
            $display("could not open the stimulus file sim/cp0_golden.txt");
            errors = 1;
        end else begin
            while (!$feof(fd)) begin
                line   = "";
                fields = 0;
                rc     = $fgets(line, fd);
                if (rc > 0 && line.getc(0) != 8'h23) begin   // Skip lines starting with #
                    fields = $sscanf(line, "%s %s %h %h %h %h", name, op, a, b, c, d);
                end
                if (fields == 6) begin
                    if (name != test_name) begin
                        if (test_name != "") begin
                            end_test();
                        end
                        test_name = name;
                    end
                    run_row(op, a, b, c, d);
                end else if (fields > 0) begin
                    $display("stimulus row has %0d fields instead of 6", fields);
                    errors++;
                end
            end
            if (test_name != "") begin
                end_test();
            end
            if (tests_passed + tests_failed == 0) begin
                $display("no test rows were found in the stimulus file");
                errors++;
            end
            $fclose(fd);
        end

        $display("%0d tests passed, %0d tests failed", tests_passed, tests_failed);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

//--- rtl/cp0_top.sv
module cp0_top #(
    parameter int          TLBNUM       = 16,
    parameter logic [31:0] COMPARE_INIT = 32'h000155cc
) (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 ws_valid,
    input  logic                 ws_ex,
    input  logic                 ws_bd,
    input  logic                 inst_mtc0,
    input  logic                 inst_eret,
    input  logic                 inst_tlbr,
    input  logic                 inst_tlbwi,
    input  logic [4:0]           ws_rd,
    input  logic [2:0]           ws_sel,
    input  cp0_pkg::word_t       ws_result,
    input  cp0_pkg::word_t       ws_pc,
    input  cp0_pkg::word_t       ws_badaddr,
    input  cp0_pkg::exc_code_t   exc_code,
    input  logic [5:0]           ext_int,
    output cp0_pkg::word_t       cp0_rdata,
    output logic                 eret_flush,
    output cp0_pkg::word_t       epc,
    output logic                 int_pending
);

    cp0_pkg::word_t              count;
    cp0_pkg::word_t              compare;
    logic                        timer_int;
    cp0_pkg::word_t              tlb_rdata;
    logic                        tlb_hit_addr;
    logic [$clog2(TLBNUM)-1:0]   index;
    cp0_pkg::tlb_entry_t         wr_entry;
    cp0_pkg::tlb_entry_t         rd_entry;
    logic                        wr_en;

    cp0_core u_core (
        .clk          (clk),
        .reset        (reset),
        .ws_valid     (ws_valid),
        .ws_ex        (ws_ex),
        .ws_bd        (ws_bd),
        .inst_mtc0    (inst_mtc0),
        .inst_eret    (inst_eret),
        .ws_rd        (ws_rd),
        .ws_sel       (ws_sel),
        .ws_result    (ws_result),
        .ws_pc        (ws_pc),
        .ws_badaddr   (ws_badaddr),
        .exc_code     (exc_code),
        .ext_int      (ext_int),
        .count        (count),
        .compare      (compare),
        .timer_int    (timer_int),
        .tlb_rdata    (tlb_rdata),
        .tlb_hit_addr (tlb_hit_addr),
        .cp0_rdata    (cp0_rdata),
        .eret_flush   (eret_flush),
        .epc          (epc),
        .int_pending  (int_pending)
    );

    cp0_timer #(
        .COMPARE_INIT (COMPARE_INIT)
    ) u_timer (
        .clk        (clk),
        .reset      (reset),
        .ws_valid   (ws_valid),
        .ws_ex      (ws_ex),
        .inst_mtc0  (inst_mtc0),
        .ws_rd      (ws_rd),
        .ws_sel     (ws_sel),
        .ws_result  (ws_result),
        .count      (count),
        .compare    (compare),
        .timer_int  (timer_int)
    );

    cp0_tlb_regs #(
        .TLBNUM (TLBNUM)
    ) u_tlb_regs (
        .clk          (clk),
        .reset        (reset),
        .ws_valid     (ws_valid),
        .ws_ex        (ws_ex),
        .inst_mtc0    (inst_mtc0),
        .inst_tlbr    (inst_tlbr),
        .inst_tlbwi   (inst_tlbwi),
        .ws_rd        (ws_rd),
        .ws_sel       (ws_sel),
        .ws_result    (ws_result),
        .rd_entry     (rd_entry),
        .tlb_rdata    (tlb_rdata),
        .tlb_hit_addr (tlb_hit_addr),
        .index        (index),
        .wr_entry     (wr_entry),
        .wr_en        (wr_en)
    );

    tlb_array #(
        .TLBNUM (TLBNUM)
    ) u_tlb_array (
        .clk      (clk),
        .wr_en    (wr_en),
        .index    (index),
        .wr_entry (wr_entry),
        .rd_entry (rd_entry)
    );

endmodule

//--- rtl/tlb_array.sv
module tlb_array #(
    parameter int TLBNUM = 16
) (
    input  logic                        clk,
    input  logic                        wr_en,
    input  logic [$clog2(TLBNUM)-1:0]   index,
    input  cp0_pkg::tlb_entry_t         wr_entry,
    output cp0_pkg::tlb_entry_t         rd_entry
);

    cp0_pkg::tlb_entry_t entries [TLBNUM];   // Loaded only by tlbwi

    always_ff @(posedge clk) begin
        if (wr_en) begin
            entries[index] <= wr_entry;
        end
    end

    // Same Index serves both tlbwi and tlbr
    assign rd_entry = entries[index];

endmodule

//--- rtl/cp0_tlb_regs.sv
module cp0_tlb_regs #(
    parameter int TLBNUM = 16
) (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        ws_valid,
    input  logic                        ws_ex,
    input  logic                        inst_mtc0,
    input  logic                        inst_tlbr,
    input  logic                        inst_tlbwi,
    input  logic [4:0]                  ws_rd,
    input  logic [2:0]                  ws_sel,
    input  cp0_pkg::word_t              ws_result,
    input  cp0_pkg::tlb_entry_t         rd_entry,
    output cp0_pkg::word_t              tlb_rdata,
    output logic                        tlb_hit_addr,
    output logic [$clog2(TLBNUM)-1:0]   index,
    output cp0_pkg::tlb_entry_t         wr_entry,
    output logic                        wr_en
);

    localparam int IDX_W = $clog2(TLBNUM);

    cp0_pkg::cp0_addr_t  addr;
    cp0_pkg::cp0_wdata_u wdata;
    logic                mtc0_we;
    logic                tlbr_en;
    logic [18:0]         entryhi_vpn2;
    logic [7:0]          entryhi_asid;
    logic [25:0]         entrylo [2];    // {pfn, c, d, v, g}
    logic [25:0]         tlbr_lo [2];
    logic [25:0]         mtc0_lo;

    assign addr      = {ws_rd, ws_sel};
    assign wdata.raw = ws_result;
    assign mtc0_we   = ws_valid && inst_mtc0 && !ws_ex;
    assign tlbr_en   = ws_valid && inst_tlbr && !ws_ex;
    assign wr_en     = ws_valid && inst_tlbwi && !ws_ex;

    assign mtc0_lo    = {wdata.entrylo.pfn, wdata.entrylo.c, wdata.entrylo.d,
                         wdata.entrylo.v, wdata.entrylo.g};
    assign tlbr_lo[0] = {rd_entry.pfn0, rd_entry.c0, rd_entry.d0, rd_entry.v0, rd_entry.g};
    assign tlbr_lo[1] = {rd_entry.pfn1, rd_entry.c1, rd_entry.d1, rd_entry.v1, rd_entry.g};

    always_ff @(posedge clk) begin
        if (reset) begin
            index <= '0;
        end else if (mtc0_we && addr == cp0_pkg::INDEX_ADDR) begin
            index <= ws_result[IDX_W-1:0];
        end
    end

    always_ff @(posedge clk) begin
        if (tlbr_en) begin
            entryhi_vpn2 <= rd_entry.vpn2;
            entryhi_asid <= rd_entry.asid;
        end else if (mtc0_we && addr == cp0_pkg::ENTRYHI_ADDR) begin
            entryhi_vpn2 <= wdata.entryhi.vpn2;
            entryhi_asid <= wdata.entryhi.asid;
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < 2; i++) begin
            if (tlbr_en) begin
                entrylo[i] <= tlbr_lo[i];
            end else if (mtc0_we &&
                         addr == (i == 0 ? cp0_pkg::ENTRYLO0_ADDR : cp0_pkg::ENTRYLO1_ADDR)) begin
                entrylo[i] <= mtc0_lo;
            end
        end
    end

    // Entry image for tlbwi is global only if both halves are
    assign wr_entry = {entryhi_vpn2, entryhi_asid, entrylo[0][0] & entrylo[1][0],
                       entrylo[0][25:1], entrylo[1][25:1]};

    always_comb begin
        tlb_hit_addr = 1'b1;
        case (addr)
            cp0_pkg::INDEX_ADDR:    tlb_rdata = {{(32-IDX_W){1'b0}}, index};
            cp0_pkg::ENTRYHI_ADDR:  tlb_rdata = {entryhi_vpn2, 5'b0, entryhi_asid};
            cp0_pkg::ENTRYLO0_ADDR: tlb_rdata = {6'b0, entrylo[0]};
            cp0_pkg::ENTRYLO1_ADDR: tlb_rdata = {6'b0, entrylo[1]};
            default: begin
                tlb_hit_addr = 1'b0;
                tlb_rdata    = '0;
            end
        endcase
    end

endmodule

//--- rtl/cp0_core.sv
module cp0_core (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 ws_valid,
    input  logic                 ws_ex,
    input  logic                 ws_bd,
    input  logic                 inst_mtc0,
    input  logic                 inst_eret,
    input  logic [4:0]           ws_rd,
    input  logic [2:0]           ws_sel,
    input  cp0_pkg::word_t       ws_result,
    input  cp0_pkg::word_t       ws_pc,
    input  cp0_pkg::word_t       ws_badaddr,
    input  cp0_pkg::exc_code_t   exc_code,
    input  logic [5:0]           ext_int,
    input  cp0_pkg::word_t       count,
    input  cp0_pkg::word_t       compare,
    input  logic                 timer_int,
    input  cp0_pkg::word_t       tlb_rdata,
    input  logic                 tlb_hit_addr,
    output cp0_pkg::word_t       cp0_rdata,
    output logic                 eret_flush,
    output cp0_pkg::word_t       epc,
    output logic                 int_pending
);

    cp0_pkg::cp0_addr_t  addr;
    cp0_pkg::cp0_wdata_u wdata;
    logic                mtc0_we;
    logic                ex_en;

    logic                status_ie;
    logic                status_exl;
    logic [7:0]          status_im;
    logic                cause_bd;
    logic [7:0]          cause_ip;
    cp0_pkg::exc_code_t  cause_exc_code;
    cp0_pkg::word_t      badvaddr;

    assign addr       = {ws_rd, ws_sel};
    assign wdata.raw  = ws_result;
    assign mtc0_we    = ws_valid && inst_mtc0 && !ws_ex;
    assign ex_en      = ws_valid && ws_ex;
    assign eret_flush = ws_valid && inst_eret && !ws_ex;

    always_ff @(posedge clk) begin
        if (reset) begin
            status_ie  <= 1'b0;
            status_exl <= 1'b0;
            status_im  <= 8'h00;
        end else if (ex_en) begin
            status_exl <= 1'b1;
        end else if (eret_flush) begin
            status_exl <= 1'b0;
        end else if (mtc0_we && addr == cp0_pkg::STATUS_ADDR) begin
            status_ie  <= wdata.status.ie;
            status_exl <= wdata.status.exl;
            status_im  <= wdata.status.im;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            cause_bd       <= 1'b0;
            cause_exc_code <= '0;
        end else if (ex_en) begin
            cause_exc_code <= exc_code;
            if (!status_exl) begin
                cause_bd <= ws_bd;   // Nested exceptions keep the first BD
            end
        end
    end

    // IP7 merges the timer with the top external line
    always_ff @(posedge clk) begin
        if (reset) begin
            cause_ip <= 8'h00;
        end else begin
            cause_ip[7:2] <= {timer_int | ext_int[5], ext_int[4:0]};
            if (mtc0_we && addr == cp0_pkg::CAUSE_ADDR) begin
                cause_ip[1:0] <= wdata.cause.ip_sw;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (ex_en && !status_exl) begin
            epc <= ws_bd ? ws_pc - 32'd4 : ws_pc;   // Point back at the branch
        end else if (mtc0_we && addr == cp0_pkg::EPC_ADDR) begin
            epc <= ws_result;
        end
    end

    always_ff @(posedge clk) begin
        if (ex_en) begin
            if (exc_code == cp0_pkg::EXC_ADES) begin
                badvaddr <= ws_badaddr;
            end else if (exc_code == cp0_pkg::EXC_ADEL) begin
                badvaddr <= (|ws_pc[1:0]) ? ws_pc : ws_badaddr;   // Fetch or load
            end
        end
    end

    assign int_pending = status_ie && !status_exl && |(cause_ip & status_im);

    always_comb begin
        if (tlb_hit_addr) begin
            cp0_rdata = tlb_rdata;
        end else begin
            case (addr)
                cp0_pkg::BADVADDR_ADDR: cp0_rdata = badvaddr;
                cp0_pkg::COUNT_ADDR:    cp0_rdata = count;
                cp0_pkg::COMPARE_ADDR:  cp0_rdata = compare;
                cp0_pkg::STATUS_ADDR:   cp0_rdata = {9'b0, 1'b1, 6'b0, status_im,
                                                     6'b0, status_exl, status_ie};
                cp0_pkg::CAUSE_ADDR:    cp0_rdata = {cause_bd, timer_int, 14'b0, cause_ip,
                                                     1'b0, cause_exc_code, 2'b0};
                cp0_pkg::EPC_ADDR:      cp0_rdata = epc;
                default:                cp0_rdata = '0;
            endcase
        end
    end

endmodule

//--- rtl/cp0_timer.sv
module cp0_timer #(
    parameter logic [31:0] COMPARE_INIT = 32'h000155cc
) (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 ws_valid,
    input  logic                 ws_ex,
    input  logic                 inst_mtc0,
    input  logic [4:0]           ws_rd,
    input  logic [2:0]           ws_sel,
    input  cp0_pkg::word_t       ws_result,
    output cp0_pkg::word_t       count,
    output cp0_pkg::word_t       compare,
    output logic                 timer_int
);

    cp0_pkg::cp0_addr_t addr;
    logic               mtc0_we;
    logic               tick;        // Count advances when set

    assign addr    = {ws_rd, ws_sel};
    assign mtc0_we = ws_valid && inst_mtc0 && !ws_ex;

    always_ff @(posedge clk) begin
        if (reset) begin
            tick <= 1'b0;
        end else begin
            tick <= ~tick;           // Free running phase that mtc0 never resets
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            count <= '0;
        end else if (mtc0_we && addr == cp0_pkg::COUNT_ADDR) begin
            count <= ws_result;
        end else if (tick) begin
            count <= count + 32'd1;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            compare <= COMPARE_INIT;
        end else if (mtc0_we && addr == cp0_pkg::COMPARE_ADDR) begin
            compare <= ws_result;
        end
    end

    // Sticky until software rewrites Compare
    always_ff @(posedge clk) begin
        if (reset) begin
            timer_int <= 1'b0;
        end else if (mtc0_we && addr == cp0_pkg::COMPARE_ADDR) begin
            timer_int <= 1'b0;
        end else if (count == compare) begin
            timer_int <= 1'b1;
        end
    end

endmodule

//--- rtl/cp0_pkg.sv
package cp0_pkg;

    typedef logic [7:0]  cp0_addr_t;   // {rd, sel}
    typedef logic [31:0] word_t;
    typedef logic [4:0]  exc_code_t;

    localparam cp0_addr_t INDEX_ADDR    = {5'd0, 3'd0};
    localparam cp0_addr_t ENTRYLO0_ADDR = {5'd2, 3'd0};
    localparam cp0_addr_t ENTRYLO1_ADDR = {5'd3, 3'd0};
    localparam cp0_addr_t BADVADDR_ADDR = {5'd8, 3'd0};
    localparam cp0_addr_t COUNT_ADDR    = {5'd9, 3'd0};
    localparam cp0_addr_t ENTRYHI_ADDR  = {5'd10, 3'd0};
    localparam cp0_addr_t COMPARE_ADDR  = {5'd11, 3'd0};
    localparam cp0_addr_t STATUS_ADDR   = {5'd12, 3'd0};
    localparam cp0_addr_t CAUSE_ADDR    = {5'd13, 3'd0};
    localparam cp0_addr_t EPC_ADDR      = {5'd14, 3'd0};

    localparam exc_code_t EXC_INT  = 5'd0;
    localparam exc_code_t EXC_ADEL = 5'd4;   // Load or fetch address error
    localparam exc_code_t EXC_ADES = 5'd5;   // Store address error

    // One view of the mtc0 write word per destination register
    typedef struct packed {
        logic [15:0] pad_hi;
        logic [7:0]  im;
        logic [5:0]  pad_lo;
        logic        exl;
        logic        ie;
    } status_view_t;

    typedef struct packed {
        logic [21:0] pad_hi;
        logic [1:0]  ip_sw;                // IP1..IP0
        logic [7:0]  pad_lo;
    } cause_view_t;

    typedef struct packed {
        logic [5:0]  pad;
        logic [19:0] pfn;
        logic [2:0]  c;
        logic        d;
        logic        v;
        logic        g;
    } entrylo_view_t;

    typedef struct packed {
        logic [18:0] vpn2;
        logic [4:0]  pad;
        logic [7:0]  asid;
    } entryhi_view_t;

    typedef union packed {
        word_t         raw;
        status_view_t  status;
        cause_view_t   cause;
        entrylo_view_t entrylo;
        entryhi_view_t entryhi;
    } cp0_wdata_u;

    typedef struct packed {
        logic [18:0] vpn2;
        logic [7:0]  asid;
        logic        g;                    // AND of both EntryLo G bits
        logic [19:0] pfn0;
        logic [2:0]  c0;
        logic        d0;
        logic        v0;
        logic [19:0] pfn1;
        logic [2:0]  c1;
        logic        d1;
        logic        v1;
    } tlb_entry_t;

endpackage
